// ==== rtl/cam_bridge_pkg.sv ====
`default_nettype none

package cam_bridge_pkg;

  // Register file geometry
  localparam int reg_addr_w = 5;
  localparam int reg_data_w = 8;

  // RGB565 pixel from the camera side
  localparam int pixel_w = 16;

  // Expanded word toward the host, 0RGB byte order
  localparam int img_word_w = 32;

  // FIFO depths
  localparam int img_fifo_depth  = 512;
  localparam int host_fifo_depth = 2048;

  // 320 x 240 frame
  localparam int frame_words = 76800;

  // Value in the reset entry that holds the image path in reset
  localparam logic [reg_data_w-1:0] soft_reset_code = 8'hFF;

  // Register addresses with a name
  // Entries not listed are plain storage
  typedef enum logic [reg_addr_w-1:0] {
    ctrl_reset  = 5'd0,
    ctrl_select = 5'd1
  } ctrl_reg_e;

endpackage

`default_nettype wire

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int width = 8,
  parameter int depth = 16
) (
  input  wire logic             bus_clk,
  input  wire logic             clear,
  input  wire logic             wr_en,
  input  wire logic [width-1:0] din,
  input  wire logic             rd_en,
  output logic      [width-1:0] dout,
  output logic                  full,
  output logic                  empty
);

  // Pointer and occupancy widths
  localparam int aw = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw = $clog2(depth + 1);
  localparam logic [aw-1:0] last_slot = aw'(depth - 1);

  logic [width-1:0] mem [depth];
  logic [aw-1:0]    wr_ptr;
  logic [aw-1:0]    rd_ptr;
  logic [cw-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // Requests that the flags allow
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // Flags straight from the occupancy register
  assign full  = (count == cw'(depth));
  assign empty = (count == '0);

  // Storage and registered read data
  always_ff @(posedge bus_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

  // Pointers and count
  always_ff @(posedge bus_clk) begin
    if (clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        // Wrap at the last slot, depth need not be a power of two
        wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ctrl_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  wire logic                                   bus_clk,
  input  wire logic                                   reset,
  input  wire cam_bridge_pkg::ctrl_reg_e              mem_addr,
  input  wire logic                                   mem_wren,
  input  wire logic [cam_bridge_pkg::reg_data_w-1:0]  mem_wr_data,
  input  wire logic                                   mem_rden,
  output logic      [cam_bridge_pkg::reg_data_w-1:0]  mem_rd_data,
  output logic                                        user_reset
);

  import cam_bridge_pkg::*;

  localparam int num_regs = 2 ** reg_addr_w;

  logic [reg_data_w-1:0] regs [num_regs];

  // Byte array, cleared on reset
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (mem_wren) begin
      regs[mem_addr] <= mem_wr_data;
    end
  end

  // Read port, holds when not read
  always_ff @(posedge bus_clk) begin
    if (mem_rden) begin
      mem_rd_data <= regs[mem_addr];
    end
  end

  // Soft reset level, one clock behind the stored entry
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      user_reset <= 1'b0;
    end else begin
      user_reset <= (regs[ctrl_reset] == soft_reset_code);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/frame_eof.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_eof #(
  parameter int unsigned frame_len = cam_bridge_pkg::frame_words
) (
  input  wire logic bus_clk,
  input  wire logic clear,
  input  wire logic word_taken,
  input  wire logic fifo_empty,
  output logic      eof
);

  // Counter only needs to reach frame_len - 1
  localparam int cw = (frame_len > 1) ? $clog2(frame_len) : 1;
  localparam logic [cw-1:0] last_idx = cw'(frame_len - 1);

  logic [cw-1:0] word_cnt;
  logic          last_word;

  // Word being read is the final one of the frame
  assign last_word = (word_cnt == last_idx);

  always_ff @(posedge bus_clk) begin
    if (clear) begin
      word_cnt <= '0;
    end else if (word_taken) begin
      word_cnt <= last_word ? '0 : word_cnt + 1'b1;
    end
  end

  // Flag stays up until the host has drained the FIFO
  always_ff @(posedge bus_clk) begin
    if (clear || fifo_empty) begin
      eof <= 1'b0;
    end else if (word_taken && last_word) begin
      eof <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/image_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module image_stream #(
  parameter int unsigned frame_len = cam_bridge_pkg::frame_words
) (
  input  wire logic                                   bus_clk,
  input  wire logic                                   reset,
  input  wire logic                                   user_reset,
  input  wire logic                                   img_valid,
  input  wire logic [cam_bridge_pkg::pixel_w-1:0]     img_data,
  input  wire logic                                   img_rden,
  output logic                                        img_ready,
  output logic      [cam_bridge_pkg::img_word_w-1:0]  img_rd_data,
  output logic                                        img_empty,
  output logic                                        img_eof
);

  import cam_bridge_pkg::*;

  logic [img_word_w-1:0] quad_data;
  logic                  fifo_clear;
  logic                  fifo_full;
  logic                  word_taken;

  // RRRRRGGG_GGGBBBBB in
  // 00000000_RRRRR000_GGGGGG00_BBBBB000 out
  assign quad_data = {8'd0,
                      img_data[15:11], 3'd0,
                      img_data[10:5],  2'd0,
                      img_data[4:0],   3'd0};

  // Either reset empties the image path
  assign fifo_clear = reset || user_reset;

  // Pixels offered while full are dropped by the FIFO
  assign img_ready = !fifo_full;

  // Only reads that actually pop a word count toward the frame
  assign word_taken = img_rden && !img_empty;

  sync_fifo #(
    .width (img_word_w),
    .depth (img_fifo_depth)
  ) i_img_fifo (
    .bus_clk (bus_clk),
    .clear   (fifo_clear),
    .wr_en   (img_valid),
    .din     (quad_data),
    .rd_en   (img_rden),
    .dout    (img_rd_data),
    .full    (fifo_full),
    .empty   (img_empty)
  );

  frame_eof #(
    .frame_len (frame_len)
  ) i_frame_eof (
    .bus_clk    (bus_clk),
    .clear      (fifo_clear),
    .word_taken (word_taken),
    .fifo_empty (img_empty),
    .eof        (img_eof)
  );

endmodule

`default_nettype wire

// ==== rtl/cam_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_bridge_top #(
  parameter int unsigned frame_len = cam_bridge_pkg::frame_words
) (
  input  wire logic                                   bus_clk,
  input  wire logic                                   reset,

  // Addressed register device
  input  wire cam_bridge_pkg::ctrl_reg_e              mem_addr,
  input  wire logic                                   mem_wren,
  input  wire logic [cam_bridge_pkg::reg_data_w-1:0]  mem_wr_data,
  input  wire logic                                   mem_rden,
  output logic      [cam_bridge_pkg::reg_data_w-1:0]  mem_rd_data,

  // Pixel source and 32-bit image reads
  input  wire logic                                   img_valid,
  input  wire logic [cam_bridge_pkg::pixel_w-1:0]     img_data,
  output logic                                        img_ready,
  input  wire logic                                   img_rden,
  output logic      [cam_bridge_pkg::img_word_w-1:0]  img_rd_data,
  output logic                                        img_empty,
  output logic                                        img_eof,

  // 8-bit host loopback
  input  wire logic                                   host_wren,
  input  wire logic [cam_bridge_pkg::reg_data_w-1:0]  host_wr_data,
  output logic                                        host_full,
  input  wire logic                                   host_rden,
  output logic      [cam_bridge_pkg::reg_data_w-1:0]  host_rd_data,
  output logic                                        host_empty,
  input  wire logic                                   host_w_open,
  input  wire logic                                   host_r_open
);

  import cam_bridge_pkg::*;

  logic user_reset;
  logic host_clear;

  // Loopback empties once both host devices are closed
  assign host_clear = reset || (!host_w_open && !host_r_open);

  ctrl_regs i_ctrl_regs (
    .bus_clk     (bus_clk),
    .reset       (reset),
    .mem_addr    (mem_addr),
    .mem_wren    (mem_wren),
    .mem_wr_data (mem_wr_data),
    .mem_rden    (mem_rden),
    .mem_rd_data (mem_rd_data),
    .user_reset  (user_reset)
  );

  image_stream #(
    .frame_len (frame_len)
  ) i_image_stream (
    .bus_clk     (bus_clk),
    .reset       (reset),
    .user_reset  (user_reset),
    .img_valid   (img_valid),
    .img_data    (img_data),
    .img_rden    (img_rden),
    .img_ready   (img_ready),
    .img_rd_data (img_rd_data),
    .img_empty   (img_empty),
    .img_eof     (img_eof)
  );

  // Same registered FIFO as the image path, byte wide
  sync_fifo #(
    .width (reg_data_w),
    .depth (host_fifo_depth)
  ) i_host_fifo (
    .bus_clk (bus_clk),
    .clear   (host_clear),
    .wr_en   (host_wren),
    .din     (host_wr_data),
    .rd_en   (host_rden),
    .dout    (host_rd_data),
    .full    (host_full),
    .empty   (host_empty)
  );

endmodule

`default_nettype wire

// ==== test/tb_cam_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cam_bridge;

  import cam_bridge_pkg::*;

  // Short frame so both frame ends are reached quickly
  localparam int frame_len  = 8;
  localparam int wait_limit = 60;

  logic                  bus_clk;
  logic                  reset;
  ctrl_reg_e             mem_addr;
  logic                  mem_wren;
  logic [reg_data_w-1:0] mem_wr_data;
  logic                  mem_rden;
  logic [reg_data_w-1:0] mem_rd_data;
  logic                  img_valid;
  logic [pixel_w-1:0]    img_data;
  logic                  img_ready;
  logic                  img_rden;
  logic [img_word_w-1:0] img_rd_data;
  logic                  img_empty;
  logic                  img_eof;
  logic                  host_wren;
  logic [reg_data_w-1:0] host_wr_data;
  logic                  host_full;
  logic                  host_rden;
  logic [reg_data_w-1:0] host_rd_data;
  logic                  host_empty;
  logic                  host_w_open;
  logic                  host_r_open;

  // Pixel table, corners of each color field plus mixed values
  logic [pixel_w-1:0] pix_tab [16] = '{
    16'hffff, 16'h0000, 16'hf800, 16'h07e0, 16'h001f, 16'h1234, 16'habcd, 16'h8410,
    16'h7bef, 16'h5555, 16'haaaa, 16'hc618, 16'h39e7, 16'h0821, 16'hfedc, 16'h4a69
  };

  // Register writes, address and value
  logic [reg_addr_w-1:0] reg_addr_tab [4] = '{5'd1, 5'd5, 5'd17, 5'd31};
  logic [reg_data_w-1:0] reg_val_tab  [4] = '{8'h5a, 8'hc3, 8'h01, 8'h80};

  // Host loopback bytes
  logic [reg_data_w-1:0] host_tab [6] = '{8'h11, 8'hfe, 8'h00, 8'h7f, 8'ha5, 8'h3c};

  cam_bridge_top #(
    .frame_len (frame_len)
  ) i_dut (
    .bus_clk      (bus_clk),
    .reset        (reset),
    .mem_addr     (mem_addr),
    .mem_wren     (mem_wren),
    .mem_wr_data  (mem_wr_data),
    .mem_rden     (mem_rden),
    .mem_rd_data  (mem_rd_data),
    .img_valid    (img_valid),
    .img_data     (img_data),
    .img_ready    (img_ready),
    .img_rden     (img_rden),
    .img_rd_data  (img_rd_data),
    .img_empty    (img_empty),
    .img_eof      (img_eof),
    .host_wren    (host_wren),
    .host_wr_data (host_wr_data),
    .host_full    (host_full),
    .host_rden    (host_rden),
    .host_rd_data (host_rd_data),
    .host_empty   (host_empty),
    .host_w_open  (host_w_open),
    .host_r_open  (host_r_open)
  );

  initial begin
    bus_clk = 1'b0;
    forever #50 bus_clk = ~bus_clk;
  end

  // 0RGB word, each field shifted up to the top of its byte
  function automatic logic [31:0] expand(input logic [15:0] p);
    logic [31:0] red;
    logic [31:0] green;
    logic [31:0] blue;
    red   = (p >> 11) & 32'h1f;
    green = (p >> 5) & 32'h3f;
    blue  = p & 32'h1f;
    return (red << 19) | (green << 10) | (blue << 3);
  endfunction

  // Flag picked by index for the wait loop
  function automatic logic flag_value(input int which);
    case (which)
      0:       return img_empty;
      1:       return img_eof;
      default: return host_empty;
    endcase
  endfunction

  // Outputs settled, inputs may change here
  task automatic step();
    @(posedge bus_clk);
    #10;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERR time %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic wait_level(input int which, input logic level, input string what);
    int n;
    n = 0;
    while (flag_value(which) !== level && n < wait_limit) begin
      step();
      n++;
    end
    assert (flag_value(which) === level) else begin
      $display("Timed out waiting for %s", what);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic write_reg(input logic [reg_addr_w-1:0] addr, input logic [7:0] data);
    mem_addr    = ctrl_reg_e'(addr);
    mem_wr_data = data;
    mem_wren    = 1'b1;
    step();
    mem_wren    = 1'b0;
  endtask

  // Data is registered, so it is checked one clock after the strobe
  task automatic read_reg(input logic [reg_addr_w-1:0] addr, input logic [7:0] exp);
    mem_addr = ctrl_reg_e'(addr);
    mem_rden = 1'b1;
    step();
    mem_rden = 1'b0;
    check_val("mem_rd_data", exp, mem_rd_data);
  endtask

  task automatic push_pixels(input int first, input int count);
    for (int i = first; i < first + count; i++) begin
      check_val("img_ready", 1, img_ready);
      img_valid = 1'b1;
      img_data  = pix_tab[i];
      step();
    end
    img_valid = 1'b0;
  endtask

  // One accepted read after a random idle gap
  task automatic read_word(input int idx, input logic exp_eof);
    int gap;
    wait_level(0, 1'b0, "image word to arrive");
    gap = $urandom % 4;
    repeat (gap) step();
    img_rden = 1'b1;
    step();
    img_rden = 1'b0;
    check_val("img_rd_data", expand(pix_tab[idx]), img_rd_data);
    check_val("img_eof", exp_eof, img_eof);
  endtask

  // Full frame, eof only after the last word, then clears on empty
  task automatic run_frame(input int first);
    push_pixels(first, frame_len);
    for (int k = 0; k < frame_len; k++) begin
      read_word(first + k, k == frame_len - 1);
    end
    check_val("img_empty", 1, img_empty);
    wait_level(1, 1'b0, "end of frame flag to drop");
    // Read with nothing queued, must not move the frame count
    img_rden = 1'b1;
    step();
    img_rden = 1'b0;
    check_val("img_empty", 1, img_empty);
  endtask

  initial begin
    void'($urandom(32'hf02ef2fe));
    reset        = 1'b1;
    mem_addr     = ctrl_reset;
    mem_wren     = 1'b0;
    mem_wr_data  = '0;
    mem_rden     = 1'b0;
    img_valid    = 1'b0;
    img_data     = '0;
    img_rden     = 1'b0;
    host_wren    = 1'b0;
    host_wr_data = '0;
    host_rden    = 1'b0;
    host_w_open  = 1'b1;
    host_r_open  = 1'b1;
    repeat (4) step();
    reset = 1'b0;
    step();

    // Idle state
    check_val("img_empty", 1, img_empty);
    check_val("host_empty", 1, host_empty);
    check_val("img_ready", 1, img_ready);
    check_val("img_eof", 0, img_eof);
    check_val("host_full", 0, host_full);

    // Register file write then readback
    for (int i = 0; i < 4; i++) begin
      write_reg(reg_addr_tab[i], reg_val_tab[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(reg_addr_tab[i], reg_val_tab[i]);
    end

    // Two frames, drained in between
    run_frame(0);
    run_frame(8);

    // Soft reset mid frame, two words already counted
    push_pixels(0, 4);
    read_word(0, 1'b0);
    read_word(1, 1'b0);
    write_reg(ctrl_reset, soft_reset_code);
    wait_level(0, 1'b1, "image FIFO to clear on soft reset");
    read_reg(ctrl_reset, soft_reset_code);
    write_reg(ctrl_reset, 8'h00);
    // user_reset lags the register by a clock
    step();
    step();
    run_frame(0);

    // Host loopback
    for (int i = 0; i < 6; i++) begin
      check_val("host_full", 0, host_full);
      host_wren    = 1'b1;
      host_wr_data = host_tab[i];
      step();
    end
    host_wren = 1'b0;
    for (int i = 0; i < 4; i++) begin
      wait_level(2, 1'b0, "host byte to arrive");
      host_rden = 1'b1;
      step();
      host_rden = 1'b0;
      check_val("host_rd_data", host_tab[i], host_rd_data);
    end
    check_val("host_empty", 0, host_empty);
    // Two bytes left, closing both devices drops them
    host_w_open = 1'b0;
    host_r_open = 1'b0;
    wait_level(2, 1'b1, "host FIFO to clear on close");
    host_w_open = 1'b1;
    host_r_open = 1'b1;
    step();

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
rtl/cam_bridge_pkg.sv
rtl/sync_fifo.sv
rtl/ctrl_regs.sv
rtl/frame_eof.sv
rtl/image_stream.sv
rtl/cam_bridge_top.sv
test/tb_cam_bridge.sv

// ==== Bender.yml ====
package:
  name: cam_bridge

sources:
  - rtl/cam_bridge_pkg.sv
  - rtl/sync_fifo.sv
  - rtl/ctrl_regs.sv
  - rtl/frame_eof.sv
  - rtl/image_stream.sv
  - rtl/cam_bridge_top.sv
  - target: test
    files:
      - test/tb_cam_bridge.sv
